//--- Makefile
# Verilator build and run for the operand pipeline testbench

VERILATOR ?= verilator
TOP       ?= operand_pipe_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "simulation gave no result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/execute_unit.sv
// EX stage: forwarded operand selection and the ALU, address and CSR results
`timescale 1ns/1ps

module execute_unit (
    input  operand_pkg::op_t      ex_op,
    input  operand_pkg::word_t    ex_rs1_val,
    input  operand_pkg::word_t    ex_rs2_val,
    input  operand_pkg::word_t    ex_csr_val,
    input  logic [15:0]           ex_imm,
    input  operand_pkg::fwd_bus_t fwd_ex,
    output operand_pkg::word_t    alu_out,
    output operand_pkg::word_t    csr_out
);

    operand_pkg::word_t op_a;
    operand_pkg::word_t op_b;
    operand_pkg::word_t op_csr;
    operand_pkg::word_t imm_ext;

    // forwarded value replaces the registered operand
    assign op_a   = fwd_ex.rs1_hit ? fwd_ex.rs1_data : ex_rs1_val;
    assign op_b   = fwd_ex.rs2_hit ? fwd_ex.rs2_data : ex_rs2_val;
    assign op_csr = fwd_ex.csr_hit ? fwd_ex.csr_data : ex_csr_val;

    // immediate is unsigned
    assign imm_ext = {16'h0000, ex_imm};

    // ==============================
    // result select
    // ==============================
    always_comb begin
        case (ex_op)
            operand_pkg::op_alu: begin
                alu_out = op_a + op_b + imm_ext;
            end
            operand_pkg::op_load: begin
                // address for the MEM stage
                alu_out = op_a + imm_ext;
            end
            operand_pkg::op_csrrw: begin
                // rd gets the old csr
                alu_out = op_csr;
            end
            default: begin
                alu_out = '0;
            end
        endcase
    end

    // new csr value for csrrw
    assign csr_out = op_a;

endmodule

//--- design/forward_unit.sv
// forwarding unit for hazard detection, forward priority and the global freeze
`timescale 1ns/1ps

module forward_unit (
    input  operand_pkg::id_inst_t    id_inst,
    input  operand_pkg::gpr_idx_t    ex_rs1,
    input  operand_pkg::gpr_idx_t    ex_rs2,
    input  operand_pkg::csr_idx_t    ex_csr,
    input  operand_pkg::stage_ctrl_t mem_ctrl,
    input  operand_pkg::word_t       mem_alu_out,
    input  operand_pkg::word_t       mem_csr_out,
    input  operand_pkg::word_t       mem_rdata,
    input  operand_pkg::wb_bus_t     wb,
    input  logic                     fetch_valid,
    input  logic                     mem_rvalid,
    input  logic                     mem_wready,
    output logic                     freeze,
    output operand_pkg::fwd_bus_t    fwd_ex,
    output operand_pkg::fwd_bus_t    fwd_seg
);

    logic mem_gpr_wr;
    logic mem_csr_wr;
    logic wb_gpr_wr;
    logic wb_csr_wr;

    logic third_rs1, third_rs2, third_csr;
    logic second_rs1, second_rs2, second_csr;
    logic first_rs1, first_rs2, first_csr;
    logic load_use_rs1, load_use_rs2;

    // ==============================
    // producer qualifiers
    // ==============================
    assign mem_gpr_wr = mem_ctrl.valid & mem_ctrl.write_gpr;
    assign mem_csr_wr = mem_ctrl.valid & mem_ctrl.write_csr;
    // wb.valid already drops while frozen
    assign wb_gpr_wr  = wb.valid & wb.write_gpr;
    assign wb_csr_wr  = wb.valid & wb.write_csr;

    // three apart the WB result is not yet in the file when ID reads it
    assign third_rs1 = (id_inst.rs1 == wb.rd) & wb_gpr_wr;
    assign third_rs2 = (id_inst.rs2 == wb.rd) & wb_gpr_wr;
    assign third_csr = (id_inst.csr == wb.csr_rd) & wb_csr_wr;

    // two apart EX needs the WB result
    assign second_rs1 = (ex_rs1 == wb.rd) & wb_gpr_wr;
    assign second_rs2 = (ex_rs2 == wb.rd) & wb_gpr_wr;
    assign second_csr = (ex_csr == wb.csr_rd) & wb_csr_wr;

    // back to back with a non-load result in MEM
    assign first_rs1 = (ex_rs1 == mem_ctrl.rd) & mem_gpr_wr & ~mem_ctrl.mem_to_reg;
    assign first_rs2 = (ex_rs2 == mem_ctrl.rd) & mem_gpr_wr & ~mem_ctrl.mem_to_reg;
    // only csrrw writes a csr, so MEM always holds the csr result here
    assign first_csr = (ex_csr == mem_ctrl.csr_rd) & mem_csr_wr;

    // load in MEM has its data ready now since memory is combinational
    assign load_use_rs1 = (ex_rs1 == mem_ctrl.rd) & mem_gpr_wr & mem_ctrl.mem_to_reg;
    assign load_use_rs2 = (ex_rs2 == mem_ctrl.rd) & mem_gpr_wr & mem_ctrl.mem_to_reg;

    // any external level low holds every stage
    assign freeze = ~(fetch_valid & mem_rvalid & mem_wready);

    // ==============================
    // EX bundle with MEM over WB
    // ==============================
    always_comb begin
        fwd_ex.rs1_hit = first_rs1 | load_use_rs1 | second_rs1;
        fwd_ex.rs2_hit = first_rs2 | load_use_rs2 | second_rs2;
        fwd_ex.csr_hit = first_csr | second_csr;

        if (load_use_rs1)    fwd_ex.rs1_data = mem_rdata;
        else if (first_rs1)  fwd_ex.rs1_data = mem_alu_out;
        else if (second_rs1) fwd_ex.rs1_data = wb.gpr_data;
        else                 fwd_ex.rs1_data = '0;

        if (load_use_rs2)    fwd_ex.rs2_data = mem_rdata;
        else if (first_rs2)  fwd_ex.rs2_data = mem_alu_out;
        else if (second_rs2) fwd_ex.rs2_data = wb.gpr_data;
        else                 fwd_ex.rs2_data = '0;

        // csr operand takes the csr result from MEM rather than the ALU word
        if (first_csr)       fwd_ex.csr_data = mem_csr_out;
        else if (second_csr) fwd_ex.csr_data = wb.csr_data;
        else                 fwd_ex.csr_data = '0;
    end

    // ==============================
    // SEG bundle from WB only
    // ==============================
    always_comb begin
        fwd_seg.rs1_hit  = third_rs1;
        fwd_seg.rs2_hit  = third_rs2;
        fwd_seg.csr_hit  = third_csr;
        fwd_seg.rs1_data = {32{third_rs1}} & wb.gpr_data;
        fwd_seg.rs2_data = {32{third_rs2}} & wb.gpr_data;
        fwd_seg.csr_data = {32{third_csr}} & wb.csr_data;
    end

endmodule

//--- design/operand_pipe_top.sv
// operand pipeline top: register file, forwarding, stage registers and EX
`timescale 1ns/1ps

module operand_pipe_top (
    input  logic                  clk,
    input  logic                  rst,
    input  operand_pkg::id_inst_t inst,
    input  logic                  fetch_valid,
    input  logic                  mem_rvalid,
    input  logic                  mem_wready,
    input  operand_pkg::word_t    mem_rdata,
    output operand_pkg::word_t    mem_addr,
    output logic                  mem_read,
    output operand_pkg::wb_bus_t  wb
);

    // ==============================
    // interconnect
    // ==============================
    logic                     freeze;
    operand_pkg::word_t       rf_rs1_data;
    operand_pkg::word_t       rf_rs2_data;
    operand_pkg::word_t       rf_csr_data;
    operand_pkg::fwd_bus_t    fwd_ex;
    operand_pkg::fwd_bus_t    fwd_seg;
    operand_pkg::stage_ctrl_t ex_ctrl;
    operand_pkg::op_t         ex_op;
    operand_pkg::gpr_idx_t    ex_rs1;
    operand_pkg::gpr_idx_t    ex_rs2;
    operand_pkg::csr_idx_t    ex_csr;
    operand_pkg::word_t       ex_rs1_val;
    operand_pkg::word_t       ex_rs2_val;
    operand_pkg::word_t       ex_csr_val;
    logic [15:0]              ex_imm;
    operand_pkg::word_t       ex_alu_out;
    operand_pkg::word_t       ex_csr_out;
    operand_pkg::stage_ctrl_t mem_ctrl;
    operand_pkg::word_t       mem_alu_out;
    operand_pkg::word_t       mem_csr_out;

    // MEM-stage address, mem_to_reg is only ever set for a load
    assign mem_addr = mem_alu_out;
    assign mem_read = mem_ctrl.mem_to_reg;

    reg_csr_file reg_csr_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1      (inst.rs1),
        .rs2      (inst.rs2),
        .csr_rs   (inst.csr),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .csr_data (rf_csr_data),
        .wr       (wb)
    );

    forward_unit forward_unit_inst (
        .id_inst     (inst),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_csr      (ex_csr),
        .mem_ctrl    (mem_ctrl),
        .mem_alu_out (mem_alu_out),
        .mem_csr_out (mem_csr_out),
        .mem_rdata   (mem_rdata),
        .wb          (wb),
        .fetch_valid (fetch_valid),
        .mem_rvalid  (mem_rvalid),
        .mem_wready  (mem_wready),
        .freeze      (freeze),
        .fwd_ex      (fwd_ex),
        .fwd_seg     (fwd_seg)
    );

    pipe_stage_regs pipe_stage_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .freeze      (freeze),
        .inst        (inst),
        .rf_rs1_data (rf_rs1_data),
        .rf_rs2_data (rf_rs2_data),
        .rf_csr_data (rf_csr_data),
        .fwd_seg     (fwd_seg),
        .ex_ctrl     (ex_ctrl),
        .ex_op       (ex_op),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .ex_csr      (ex_csr),
        .ex_rs1_val  (ex_rs1_val),
        .ex_rs2_val  (ex_rs2_val),
        .ex_csr_val  (ex_csr_val),
        .ex_imm      (ex_imm),
        .ex_alu_out  (ex_alu_out),
        .ex_csr_out  (ex_csr_out),
        .mem_ctrl    (mem_ctrl),
        .mem_alu_out (mem_alu_out),
        .mem_csr_out (mem_csr_out),
        .mem_rdata   (mem_rdata),
        .wb          (wb)
    );

    execute_unit execute_unit_inst (
        .ex_op      (ex_op),
        .ex_rs1_val (ex_rs1_val),
        .ex_rs2_val (ex_rs2_val),
        .ex_csr_val (ex_csr_val),
        .ex_imm     (ex_imm),
        .fwd_ex     (fwd_ex),
        .alu_out    (ex_alu_out),
        .csr_out    (ex_csr_out)
    );

endmodule

//--- design/operand_pkg.sv
// operand path package: shared word, index, instruction and bus types
package operand_pkg;

    localparam int N_GPR = 32;
    localparam int N_CSR = 4;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  gpr_idx_t;
    typedef logic [1:0]  csr_idx_t;

    typedef enum logic [1:0] {
        op_nop   = 2'd0,
        op_alu   = 2'd1,
        op_load  = 2'd2,
        op_csrrw = 2'd3
    } op_t;

    // instruction descriptor as presented at ID
    typedef struct packed {
        op_t         op;
        gpr_idx_t    rd;
        gpr_idx_t    rs1;
        gpr_idx_t    rs2;
        csr_idx_t    csr;
        logic [15:0] imm;
    } id_inst_t;

    // control that rides along with the instruction from EX to WB
    typedef struct packed {
        logic     valid;
        logic     write_gpr;
        logic     write_csr;
        logic     mem_to_reg;
        gpr_idx_t rd;
        csr_idx_t csr_rd;
    } stage_ctrl_t;

    // forwarded operands plus per-operand hit flags
    typedef struct packed {
        word_t rs1_data;
        word_t rs2_data;
        word_t csr_data;
        logic  rs1_hit;
        logic  rs2_hit;
        logic  csr_hit;
    } fwd_bus_t;

    // writeback port, also the register file write port
    typedef struct packed {
        logic     valid;
        logic     write_gpr;
        gpr_idx_t rd;
        word_t    gpr_data;
        logic     write_csr;
        csr_idx_t csr_rd;
        word_t    csr_data;
    } wb_bus_t;

endpackage

//--- design/pipe_stage_regs.sv
// ID decode plus the ID/EX, EX/MEM and MEM/WB registers under global freeze
`timescale 1ns/1ps

module pipe_stage_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     freeze,
    input  operand_pkg::id_inst_t    inst,
    input  operand_pkg::word_t       rf_rs1_data,
    input  operand_pkg::word_t       rf_rs2_data,
    input  operand_pkg::word_t       rf_csr_data,
    input  operand_pkg::fwd_bus_t    fwd_seg,
    output operand_pkg::stage_ctrl_t ex_ctrl,
    output operand_pkg::op_t         ex_op,
    output operand_pkg::gpr_idx_t    ex_rs1,
    output operand_pkg::gpr_idx_t    ex_rs2,
    output operand_pkg::csr_idx_t    ex_csr,
    output operand_pkg::word_t       ex_rs1_val,
    output operand_pkg::word_t       ex_rs2_val,
    output operand_pkg::word_t       ex_csr_val,
    output logic [15:0]              ex_imm,
    input  operand_pkg::word_t       ex_alu_out,
    input  operand_pkg::word_t       ex_csr_out,
    output operand_pkg::stage_ctrl_t mem_ctrl,
    output operand_pkg::word_t       mem_alu_out,
    output operand_pkg::word_t       mem_csr_out,
    input  operand_pkg::word_t       mem_rdata,
    output operand_pkg::wb_bus_t     wb
);

    operand_pkg::stage_ctrl_t id_ctrl;
    operand_pkg::stage_ctrl_t wb_ctrl;
    operand_pkg::word_t       mem_wb_data;
    operand_pkg::word_t       wb_gpr_data;
    operand_pkg::word_t       wb_csr_data;

    // ==============================
    // ID decode
    // ==============================
    always_comb begin
        id_ctrl.valid      = 1'b1;
        id_ctrl.write_gpr  = (inst.op != operand_pkg::op_nop) && (inst.rd != '0);
        id_ctrl.write_csr  = (inst.op == operand_pkg::op_csrrw);
        id_ctrl.mem_to_reg = (inst.op == operand_pkg::op_load);
        id_ctrl.rd         = inst.rd;
        id_ctrl.csr_rd     = inst.csr;
    end

    // ==============================
    // control through the stages
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_ctrl  <= '0;
            ex_op    <= operand_pkg::op_nop;
            mem_ctrl <= '0;
            wb_ctrl  <= '0;
        end else if (!freeze) begin
            ex_ctrl  <= id_ctrl;
            ex_op    <= inst.op;
            mem_ctrl <= ex_ctrl;
            wb_ctrl  <= mem_ctrl;
        end
    end

    // load data or ALU word heads to WB
    assign mem_wb_data = mem_ctrl.mem_to_reg ? mem_rdata : mem_alu_out;

    // payload, operands take the WB value on a SEG hit
    always_ff @(posedge clk) begin
        if (!freeze) begin
            ex_rs1     <= inst.rs1;
            ex_rs2     <= inst.rs2;
            ex_csr     <= inst.csr;
            ex_imm     <= inst.imm;
            ex_rs1_val <= fwd_seg.rs1_hit ? fwd_seg.rs1_data : rf_rs1_data;
            ex_rs2_val <= fwd_seg.rs2_hit ? fwd_seg.rs2_data : rf_rs2_data;
            ex_csr_val <= fwd_seg.csr_hit ? fwd_seg.csr_data : rf_csr_data;

            mem_alu_out <= ex_alu_out;
            mem_csr_out <= ex_csr_out;

            wb_gpr_data <= mem_wb_data;
            wb_csr_data <= mem_csr_out;
        end
    end

    // writeback port, held off while frozen and for nop
    always_comb begin
        wb.valid     = wb_ctrl.valid & (wb_ctrl.write_gpr | wb_ctrl.write_csr) & ~freeze;
        wb.write_gpr = wb_ctrl.write_gpr;
        wb.rd        = wb_ctrl.rd;
        wb.gpr_data  = wb_gpr_data;
        wb.write_csr = wb_ctrl.write_csr;
        wb.csr_rd    = wb_ctrl.csr_rd;
        wb.csr_data  = wb_csr_data;
    end

endmodule

//--- design/reg_csr_file.sv
// general register file and CSR bank, combinational read, written from WB
`timescale 1ns/1ps

module reg_csr_file (
    input  logic                 clk,
    input  logic                 rst,
    input  operand_pkg::gpr_idx_t rs1,
    input  operand_pkg::gpr_idx_t rs2,
    input  operand_pkg::csr_idx_t csr_rs,
    output operand_pkg::word_t    rs1_data,
    output operand_pkg::word_t    rs2_data,
    output operand_pkg::word_t    csr_data,
    input  operand_pkg::wb_bus_t  wr
);

    operand_pkg::word_t gpr [operand_pkg::N_GPR];
    operand_pkg::word_t csr [operand_pkg::N_CSR];

    logic gpr_we;
    logic csr_we;

    // x0 never takes a write, so it stays at its reset value
    assign gpr_we = wr.valid & wr.write_gpr & (wr.rd != '0);
    assign csr_we = wr.valid & wr.write_csr;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < operand_pkg::N_GPR; i++) begin
                gpr[i] <= '0;
            end
            for (int j = 0; j < operand_pkg::N_CSR; j++) begin
                csr[j] <= '0;
            end
        end else begin
            if (gpr_we) begin
                gpr[wr.rd] <= wr.gpr_data;
            end
            if (csr_we) begin
                csr[wr.csr_rd] <= wr.csr_data;
            end
        end
    end

    // plain array reads, a same-cycle write is not visible here
    assign rs1_data = (rs1 == '0) ? '0 : gpr[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : gpr[rs2];
    assign csr_data = csr[csr_rs];

endmodule

//--- sources.f
design/operand_pkg.sv
design/reg_csr_file.sv
design/forward_unit.sv
design/pipe_stage_regs.sv
design/execute_unit.sv
design/operand_pipe_top.sv
tests/wb_checker.sv
tests/operand_pipe_tb.sv

//--- tests/operand_pipe_tb.sv
// operand pipeline testbench with file-driven issue, random freeze levels and memory model
`timescale 1ns/1ps

module operand_pipe_tb;

    localparam int MAX_LINES    = 64;
    localparam int FIELDS       = 8;
    localparam int CLEAN_LINES  = 12;
    localparam int DRAIN_CYCLES = 10;

    logic                  clk;
    logic                  rst;
    operand_pkg::id_inst_t inst;
    logic                  fetch_valid;
    logic                  mem_rvalid;
    logic                  mem_wready;
    operand_pkg::word_t    mem_rdata;
    operand_pkg::word_t    mem_addr;
    logic                  mem_read;
    operand_pkg::wb_bus_t  wb;

    logic [31:0] stim [MAX_LINES*FIELDS];
    logic [15:0] lfsr;
    logic        timed_out;
    int          n_lines;
    int          issue_idx;
    int          cycle_count;
    int          cycle_limit;
    int          tb_errors;
    int          total_errors;
    int          compared;
    int          mismatches;
    int          pending;
    int          other_errors;

    // data memory answering in the same cycle
    assign mem_rdata = mem_read ? {mem_addr[15:0], ~mem_addr[15:0]} : '0;

    operand_pipe_top operand_pipe_top_inst (
        .clk         (clk),
        .rst         (rst),
        .inst        (inst),
        .fetch_valid (fetch_valid),
        .mem_rvalid  (mem_rvalid),
        .mem_wready  (mem_wready),
        .mem_rdata   (mem_rdata),
        .mem_addr    (mem_addr),
        .mem_read    (mem_read),
        .wb          (wb)
    );

    wb_checker wb_checker_inst (
        .clk          (clk),
        .rst          (rst),
        .inst         (inst),
        .fetch_valid  (fetch_valid),
        .mem_rvalid   (mem_rvalid),
        .mem_wready   (mem_wready),
        .mem_read     (mem_read),
        .wb           (wb),
        .compared     (compared),
        .mismatches   (mismatches),
        .pending      (pending),
        .other_errors (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==============================
    // random ready levels
    // ==============================
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b    = lfsr[0];
    endtask

    // low only when all three bits are zero
    task automatic draw_level(output logic level);
        logic b0;
        logic b1;
        logic b2;
        take_bit(b0);
        take_bit(b1);
        take_bit(b2);
        level = b0 | b1 | b2;
    endtask

    // ==============================
    // stimulus
    // ==============================
    task automatic load_stimulus();
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            stim[i] = '1;
        end
        $readmemh("tests/operand_stimulus.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && stim[n_lines * FIELDS] != '1) begin
            n_lines++;
        end
    endtask

    function automatic operand_pkg::id_inst_t line_inst(input int idx);
        operand_pkg::id_inst_t r;
        int base;
        base  = idx * FIELDS;
        r.op  = operand_pkg::op_t'(stim[base][1:0]);
        r.rd  = stim[base + 1][4:0];
        r.rs1 = stim[base + 2][4:0];
        r.rs2 = stim[base + 3][4:0];
        r.csr = stim[base + 4][1:0];
        r.imm = stim[base + 5][15:0];
        return r;
    endfunction

    // current line or a nop once the file is used up
    task automatic drive_inputs();
        logic lv_fetch;
        logic lv_rvalid;
        logic lv_wready;
        if (issue_idx < n_lines) begin
            inst = line_inst(issue_idx);
        end else begin
            inst = '0;
        end
        if (issue_idx < CLEAN_LINES) begin
            lv_fetch  = 1'b1;
            lv_rvalid = 1'b1;
            lv_wready = 1'b1;
        end else begin
            draw_level(lv_fetch);
            draw_level(lv_rvalid);
            draw_level(lv_wready);
        end
        fetch_valid = lv_fetch;
        mem_rvalid  = lv_rvalid;
        mem_wready  = lv_wready;
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        rst         = 1'b1;
        inst        = '0;
        fetch_valid = 1'b1;
        mem_rvalid  = 1'b1;
        mem_wready  = 1'b1;
        lfsr        = 16'd86;
        timed_out   = 1'b0;
        issue_idx   = 0;
        cycle_count = 0;
        tb_errors   = 0;

        load_stimulus();
        if (n_lines == 0) begin
            $display("stimulus file holds no instruction lines");
            tb_errors++;
        end
        cycle_limit = 20 * n_lines + 50;

        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;
        drive_inputs();

        while (!timed_out && (issue_idx < n_lines || pending != 0)) begin
            @(posedge clk);
            cycle_count++;
            // the line was taken if this edge was unfrozen
            if (fetch_valid && mem_rvalid && mem_wready && issue_idx < n_lines) begin
                issue_idx++;
            end
            if (cycle_count >= cycle_limit) begin
                timed_out = 1'b1;
            end
            #5;
            drive_inputs();
        end

        // a few more cycles to catch stray writebacks
        if (!timed_out) begin
            repeat (DRAIN_CYCLES) begin
                @(posedge clk);
                #5;
                drive_inputs();
            end
        end

        if (timed_out) begin
            $display("timeout after %0d cycles with %0d of %0d lines issued", cycle_count,
                     issue_idx, n_lines);
            tb_errors++;
        end
        if (pending != 0) begin
            $display("%0d expected writebacks never appeared", pending);
            tb_errors++;
        end
        total_errors = mismatches + other_errors + tb_errors;
        $display("writebacks compared: %0d, value mismatches: %0d, other errors: %0d",
                 compared, mismatches, other_errors + tb_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tests/operand_stimulus.txt
// columns (hex): op rd rs1 rs2 csr imm expected_gpr expected_csr
// op 0 nop, 1 alu, 2 load, 3 csrrw; expected values count only where that write happens
1 01 00 00 0 1234 00001234 00000000
1 02 00 00 0 5678 00005678 00000000
1 03 00 00 0 00ff 000000ff 00000000
0 00 00 00 0 0000 00000000 00000000
3 04 01 00 1 0000 00000000 00001234
1 06 01 02 0 0010 000068bc 00000000
1 07 06 06 0 0001 0000d179 00000000
3 08 07 00 1 0000 00001234 0000d179
3 09 08 00 1 0000 0000d179 00001234
2 0a 09 00 0 0100 d2792d86 00000000
1 0b 0a 01 0 0000 d2793fba 00000000
2 0c 00 00 0 abcd abcd5432 00000000
1 0d 01 0c 0 0002 abcd6668 00000000
1 0e 00 00 0 0111 00000111 00000000
1 0f 00 00 0 0222 00000222 00000000
1 10 0e 00 0 0000 00000111 00000000
1 11 0e 0f 0 0000 00000333 00000000
1 0e 00 00 0 0444 00000444 00000000
1 0e 0e 00 0 0001 00000445 00000000
1 12 0e 0e 0 0000 0000088a 00000000
3 13 12 00 3 0000 00000000 0000088a
1 14 13 00 0 0010 00000010 00000000
3 15 14 00 3 0000 0000088a 00000010
1 00 01 00 0 7777 00000000 00000000
1 16 00 00 0 0005 00000005 00000000
3 00 16 00 0 0000 00000000 00000005
1 17 00 16 0 0001 00000006 00000000
3 18 00 00 0 0000 00000005 00000000
2 19 17 00 0 1000 1006eff9 00000000
1 1a 19 18 0 0020 1006f01e 00000000
3 1b 1a 00 0 0000 00000000 1006f01e
1 1c 1b 1a 0 ffff 1007f01d 00000000
3 1d 1c 00 0 0000 1006f01e 1007f01d
0 00 00 00 0 0000 00000000 00000000

//--- tests/wb_checker.sv
// writeback checker matching each DUT writeback with the next expected write from the file
`timescale 1ns/1ps

module wb_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  operand_pkg::id_inst_t inst,
    input  logic                  fetch_valid,
    input  logic                  mem_rvalid,
    input  logic                  mem_wready,
    input  logic                  mem_read,
    input  operand_pkg::wb_bus_t  wb,
    output int                    compared,
    output int                    mismatches,
    output int                    pending,
    output int                    other_errors
);

    localparam int MAX_LINES = 64;
    localparam int FIELDS    = 8;

    logic [31:0]          stim [MAX_LINES*FIELDS];
    operand_pkg::wb_bus_t exp_q [$];
    int                   acc_q [$];
    int                   edge_count;
    operand_pkg::wb_bus_t accepted;
    logic                 ex_load;
    logic                 mem_load;

    // write flags follow from op and rd alone
    function automatic operand_pkg::wb_bus_t decode_write(
        input operand_pkg::op_t      op,
        input operand_pkg::gpr_idx_t rd,
        input operand_pkg::csr_idx_t csr,
        input operand_pkg::word_t    gpr_val,
        input operand_pkg::word_t    csr_val
    );
        operand_pkg::wb_bus_t e;
        e.write_gpr = (op != operand_pkg::op_nop) && (rd != '0);
        e.write_csr = (op == operand_pkg::op_csrrw);
        e.valid     = e.write_gpr | e.write_csr;
        e.rd        = rd;
        e.gpr_data  = gpr_val;
        e.csr_rd    = csr;
        e.csr_data  = csr_val;
        return e;
    endfunction

    task automatic load_expected();
        operand_pkg::wb_bus_t e;
        int line;
        int base;
        for (int i = 0; i < MAX_LINES * FIELDS; i++) begin
            stim[i] = '1;
        end
        $readmemh("tests/operand_stimulus.txt", stim);
        line = 0;
        while (line < MAX_LINES && stim[line * FIELDS] != '1) begin
            base = line * FIELDS;
            e = decode_write(operand_pkg::op_t'(stim[base][1:0]), stim[base + 1][4:0],
                             stim[base + 4][1:0], stim[base + 6], stim[base + 7]);
            // nop and x0-only lines leave no trace on wb
            if (e.valid) begin
                exp_q.push_back(e);
            end
            line++;
        end
    endtask

    task automatic check_value(input string name, input operand_pkg::word_t got,
                               input operand_pkg::word_t want);
        if (got !== want) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h (writeback %0d)",
                     name, got, want, compared);
            mismatches++;
        end
    endtask

    // ==============================
    // one writeback event
    // ==============================
    task automatic check_writeback();
        operand_pkg::wb_bus_t e;
        int acc;
        if (exp_q.size() == 0) begin
            $display("extra writeback to x%0d after all expected writes were seen", wb.rd);
            other_errors++;
        end else begin
            e = exp_q.pop_front();
            pending = exp_q.size();
            compared++;
            check_value("wb.write_gpr", {31'd0, wb.write_gpr}, {31'd0, e.write_gpr});
            check_value("wb.write_csr", {31'd0, wb.write_csr}, {31'd0, e.write_csr});
            if (e.write_gpr) begin
                check_value("wb.rd", {27'd0, wb.rd}, {27'd0, e.rd});
                check_value("wb.gpr_data", wb.gpr_data, e.gpr_data);
            end
            if (e.write_csr) begin
                check_value("wb.csr_rd", {30'd0, wb.csr_rd}, {30'd0, e.csr_rd});
                check_value("wb.csr_data", wb.csr_data, e.csr_data);
            end
        end
        // two more unfrozen edges carry it through MEM into WB
        if (acc_q.size() == 0) begin
            $display("writeback seen with no accepted instruction waiting for it");
            other_errors++;
        end else begin
            acc = acc_q.pop_front();
            if (edge_count != acc + 2) begin
                $display("writeback %0d came %0d unfrozen edges after acceptance, not 2",
                         compared, edge_count - acc);
                other_errors++;
            end
        end
    endtask

    // sampled mid-cycle when inputs and wb have settled
    initial begin
        compared     = 0;
        mismatches   = 0;
        other_errors = 0;
        edge_count   = 0;
        ex_load      = 1'b0;
        mem_load     = 1'b0;
        load_expected();
        pending = exp_q.size();
        forever begin
            @(negedge clk);
            if (rst) begin
                acc_q.delete();
                edge_count = 0;
                ex_load    = 1'b0;
                mem_load   = 1'b0;
            end else begin
                if (wb.valid) begin
                    check_writeback();
                end
                // read strobe up exactly while a load sits in MEM
                if (mem_read !== mem_load) begin
                    $display("[FAIL] mem_read: got 0x%0h, expected 0x%0h", mem_read, mem_load);
                    mismatches++;
                end
                if (fetch_valid && mem_rvalid && mem_wready) begin
                    edge_count++;
                    mem_load = ex_load;
                    ex_load  = (inst.op == operand_pkg::op_load);
                    accepted = decode_write(inst.op, inst.rd, inst.csr, '0, '0);
                    if (accepted.valid) begin
                        acc_q.push_back(edge_count);
                    end
                end
            end
        end
    end

endmodule
